/* logic/aer_pkg.sv */
`include "snn_ff_params.svh"

package aer_pkg;

    // neuron indices on each side of the core
    typedef logic [$clog2(`SNN_NUM_PRE)-1:0]  pre_addr_t;
    typedef logic [$clog2(`SNN_NUM_POST)-1:0] post_addr_t;

    // input link word, tick flag on top
    // tick set means end of time step, addr then ignored
    typedef struct packed {
        logic      tick;
        pre_addr_t addr;
    } aer_in_t;

    // output link carries only the fired neuron index
    typedef post_addr_t aer_out_t;

endpackage

/* logic/aer_receiver.sv */
`timescale 1ns/10ps

module aer_receiver
    import aer_pkg::*;
(
    input  logic    CLK,
    input  logic    rst,
    // four-phase input link
    input  aer_in_t aer_in_addr,
    input  logic    aer_in_req,
    output logic    aer_in_ack,
    // to input FIFO
    output aer_in_t ev_data,
    output logic    ev_valid,
    input  logic    ev_ready
);

    typedef enum logic {
        RX_IDLE,    // waiting for req
        RX_ACK      // ack high, waiting for req to drop
    } rx_state_t;

    rx_state_t state;

    // push once, on the cycle req is first seen with the queue open
    assign ev_valid   = (state == RX_IDLE) && aer_in_req;
    assign ev_data    = aer_in_addr;    // sender holds addr while req is high
    assign aer_in_ack = (state == RX_ACK);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (ev_valid && ev_ready) begin
                        state <= RX_ACK;    // ack next cycle
                    end
                end
                RX_ACK: begin
                    if (!aer_in_req) begin
                        state <= RX_IDLE;   // ack drops next cycle
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* logic/aer_transmitter.sv */
`timescale 1ns/10ps

module aer_transmitter
    import aer_pkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    // from output FIFO
    input  aer_out_t spike_addr,
    input  logic     spike_valid,
    output logic     spike_ready,
    // four-phase output link
    output aer_out_t aer_out_addr,
    output logic     aer_out_req,
    input  logic     aer_out_ack
);

    typedef enum logic [1:0] {
        TX_IDLE,    // free to pop
        TX_REQ,     // req high until ack
        TX_WAIT     // req low until ack drops
    } tx_state_t;

    tx_state_t state;
    aer_out_t  addr_q;

    assign spike_ready  = (state == TX_IDLE);
    assign aer_out_req  = (state == TX_REQ);
    assign aer_out_addr = addr_q;   // stable for the whole exchange

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (spike_valid) begin
                        state <= TX_REQ;    // pop now, req next cycle
                    end
                end
                TX_REQ: begin
                    if (aer_out_ack) begin
                        state <= TX_WAIT;
                    end
                end
                TX_WAIT: begin
                    if (!aer_out_ack) begin
                        state <= TX_IDLE;   // four phases complete
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // address register, loaded on pop only
    always_ff @(posedge CLK) begin
        if (spike_valid && spike_ready) begin
            addr_q <= spike_addr;
        end
    end

endmodule

/* logic/event_fifo.sv */
`timescale 1ns/10ps
`include "snn_ff_params.svh"

module event_fifo
    import aer_pkg::*;
#(
    parameter type payload_t = aer_in_t,
    parameter int  DEPTH     = `SNN_FIFO_DEPTH
) (
    input  logic     CLK,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t                   buffer [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;     // fill level, 0..DEPTH
    logic                       push;
    logic                       pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != 0);
    assign out_data  = buffer[rd_ptr];     // head, visible cycle after push
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // storage
    always_ff @(posedge CLK) begin
        if (push) begin
            buffer[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge CLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + push - pop;    // simultaneous push/pop keeps level
        end
    end

endmodule

/* logic/neuron_array.sv */
`timescale 1ns/10ps
`include "snn_ff_params.svh"

module neuron_array
    import aer_pkg::*;
    import neuron_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    // from synapse read stage
    input  logic        syn_tick,
    input  weight_row_t syn_row,
    input  logic        syn_valid,
    output logic        syn_ready,
    // fired indices to output FIFO
    output aer_out_t    spike_addr,
    output logic        spike_valid,
    input  logic        spike_ready,
    // per-sample result
    output logic        sample_done,
    output goodness_t   goodness
);

    localparam membrane_t MEM_MAX = {1'b0, {(`SNN_MEM_W-1){1'b1}}};

    typedef enum logic {
        NA_IDLE,    // accepting events
        NA_SCAN     // walking neurons after a tick
    } na_state_t;

    na_state_t  state;
    membrane_t  mem     [`SNN_NUM_POST];
    spike_cnt_t cnt     [`SNN_NUM_POST];
    spike_cnt_t cnt_nxt [`SNN_NUM_POST];
    post_addr_t scan_idx;
    logic [$clog2(`SNN_TIME_STEPS+1)-1:0] tick_cnt;
    logic       fire;
    logic       step;
    logic       last_step;
    goodness_t  good_sum;

    // membrane + weight, floored at 0 and capped at MEM_MAX
    function automatic membrane_t clamp_add(membrane_t m, weight_t w);
        logic signed [`SNN_MEM_W:0] s;  // one guard bit
        s = m + w;
        if (s < 0) begin
            return '0;
        end else if (s > MEM_MAX) begin
            return MEM_MAX;
        end
        return s[`SNN_MEM_W-1:0];
    endfunction

    // ---------------------------------------------------------------------------
    // scan control
    // ---------------------------------------------------------------------------
    assign syn_ready   = (state == NA_IDLE);    // busy for the whole scan
    assign fire        = (state == NA_SCAN) && (mem[scan_idx] >= `SNN_THRESHOLD);
    assign spike_valid = fire;
    assign spike_addr  = scan_idx;
    assign step        = (state == NA_SCAN) && (!fire || spike_ready);  // stall on full FIFO
    assign last_step   = step && (scan_idx == post_addr_t'(`SNN_NUM_POST-1));

    // counts after this cycle, folded in so goodness sees the final tick
    always_comb begin
        good_sum = '0;
        for (int i = 0; i < `SNN_NUM_POST; i++) begin
            cnt_nxt[i] = cnt[i];
            if (step && fire && scan_idx == i && cnt[i] != '1) begin
                cnt_nxt[i] = cnt[i] + 1'b1;     // saturating
            end
            good_sum = good_sum + goodness_t'(cnt_nxt[i]) * goodness_t'(cnt_nxt[i]);
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state       <= NA_IDLE;
            scan_idx    <= '0;
            tick_cnt    <= '0;
            sample_done <= 1'b0;
            goodness    <= '0;
            for (int i = 0; i < `SNN_NUM_POST; i++) begin
                mem[i] <= '0;
                cnt[i] <= '0;
            end
        end else begin
            sample_done <= 1'b0;
            case (state)
                NA_IDLE: begin
                    if (syn_valid && syn_tick) begin
                        state    <= NA_SCAN;
                        scan_idx <= '0;
                        tick_cnt <= tick_cnt + 1'b1;
                    end else if (syn_valid) begin
                        // all neurons integrate in the same cycle
                        for (int i = 0; i < `SNN_NUM_POST; i++) begin
                            mem[i] <= clamp_add(mem[i], syn_row[i]);
                        end
                    end
                end
                NA_SCAN: begin
                    if (step) begin
                        if (fire) begin
                            mem[scan_idx] <= '0;    // reset on spike
                        end
                        for (int i = 0; i < `SNN_NUM_POST; i++) begin
                            cnt[i] <= cnt_nxt[i];
                        end
                        scan_idx <= scan_idx + 1'b1;
                    end
                    if (last_step) begin
                        state <= NA_IDLE;
                        if (tick_cnt == `SNN_TIME_STEPS) begin
                            // end of sample, report and start clean
                            sample_done <= 1'b1;
                            goodness    <= good_sum;
                            tick_cnt    <= '0;
                            for (int i = 0; i < `SNN_NUM_POST; i++) begin
                                mem[i] <= '0;
                                cnt[i] <= '0;
                            end
                        end
                    end
                end
                default: state <= NA_IDLE;
            endcase
        end
    end

endmodule

/* logic/neuron_pkg.sv */
`include "snn_ff_params.svh"

package neuron_pkg;

    // one synapse weight, two's complement
    typedef logic signed [`SNN_WEIGHT_W-1:0] weight_t;

    // all weights leaving one input neuron
    // element i feeds output neuron i, elements stay signed
    typedef weight_t [`SNN_NUM_POST-1:0] weight_row_t;

    // membrane potential
    typedef logic signed [`SNN_MEM_W-1:0] membrane_t;

    // spikes per neuron over a sample, 0..TIME_STEPS
    typedef logic [$clog2(`SNN_TIME_STEPS+1)-1:0] spike_cnt_t;

    // sum of squared counts, worst case NUM_POST * TIME_STEPS^2
    typedef logic [$clog2(`SNN_NUM_POST*`SNN_TIME_STEPS*`SNN_TIME_STEPS+1)-1:0] goodness_t;

endpackage

/* logic/snn_ff_core.sv */
`timescale 1ns/10ps
`include "snn_ff_params.svh"

module snn_ff_core
    import aer_pkg::*;
    import neuron_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    // input AER link
    input  aer_in_t    aer_in_addr,
    input  logic       aer_in_req,
    output logic       aer_in_ack,
    // weight programming
    input  logic       prog_en,
    input  pre_addr_t  prog_pre,
    input  post_addr_t prog_post,
    input  weight_t    prog_weight,
    // output AER link
    output aer_out_t   aer_out_addr,
    output logic       aer_out_req,
    input  logic       aer_out_ack,
    // sample result
    output logic       sample_done,
    output goodness_t  goodness
);

    // ---------------------------------------------------------------------------
    // stage wires, named after the producing side
    // ---------------------------------------------------------------------------
    aer_in_t     rx_data;
    logic        rx_valid, rx_ready;
    aer_in_t     q_in_data;
    logic        q_in_valid, q_in_ready;
    logic        syn_tick, syn_valid, syn_ready;
    weight_row_t syn_row;
    aer_out_t    spike_addr;
    logic        spike_valid, spike_ready;
    aer_out_t    q_out_data;
    logic        q_out_valid, q_out_ready;

    aer_receiver u_rx (
        .CLK(CLK), .rst(rst),
        .aer_in_addr(aer_in_addr), .aer_in_req(aer_in_req), .aer_in_ack(aer_in_ack),
        .ev_data(rx_data), .ev_valid(rx_valid), .ev_ready(rx_ready)
    );

    event_fifo #(.payload_t(aer_in_t), .DEPTH(`SNN_FIFO_DEPTH)) u_in_fifo (
        .CLK(CLK), .rst(rst),
        .in_data(rx_data), .in_valid(rx_valid), .in_ready(rx_ready),
        .out_data(q_in_data), .out_valid(q_in_valid), .out_ready(q_in_ready)
    );

    synapse_array u_syn (
        .CLK(CLK), .rst(rst),
        .prog_en(prog_en), .prog_pre(prog_pre), .prog_post(prog_post),
        .prog_weight(prog_weight),
        .ev_data(q_in_data), .ev_valid(q_in_valid), .ev_ready(q_in_ready),
        .syn_tick(syn_tick), .syn_row(syn_row), .syn_valid(syn_valid),
        .syn_ready(syn_ready)
    );

    neuron_array u_neur (
        .CLK(CLK), .rst(rst),
        .syn_tick(syn_tick), .syn_row(syn_row), .syn_valid(syn_valid),
        .syn_ready(syn_ready),
        .spike_addr(spike_addr), .spike_valid(spike_valid), .spike_ready(spike_ready),
        .sample_done(sample_done), .goodness(goodness)
    );

    // spikes queue here while the output ack is slow
    event_fifo #(.payload_t(aer_out_t), .DEPTH(`SNN_FIFO_DEPTH)) u_out_fifo (
        .CLK(CLK), .rst(rst),
        .in_data(spike_addr), .in_valid(spike_valid), .in_ready(spike_ready),
        .out_data(q_out_data), .out_valid(q_out_valid), .out_ready(q_out_ready)
    );

    aer_transmitter u_tx (
        .CLK(CLK), .rst(rst),
        .spike_addr(q_out_data), .spike_valid(q_out_valid), .spike_ready(q_out_ready),
        .aer_out_addr(aer_out_addr), .aer_out_req(aer_out_req), .aer_out_ack(aer_out_ack)
    );

endmodule

/* logic/snn_ff_params.svh */
`ifndef SNN_FF_PARAMS_SVH
`define SNN_FF_PARAMS_SVH

// ---------------------------------------------------------------------------
// network size
// ---------------------------------------------------------------------------
`define SNN_NUM_PRE     16      // input neurons, one weight row each
`define SNN_NUM_POST    8       // output neurons, updated in parallel

// ---------------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------------
`define SNN_WEIGHT_W    8       // signed synapse weight
`define SNN_MEM_W       12      // signed membrane, clamped at 0 from below

// ---------------------------------------------------------------------------
// neuron dynamics and buffering
// ---------------------------------------------------------------------------
`define SNN_THRESHOLD   64      // fire when membrane >= this
`define SNN_TIME_STEPS  8       // ticks per sample
`define SNN_FIFO_DEPTH  4       // input event and output spike queues

`endif

/* logic/synapse_array.sv */
`timescale 1ns/10ps
`include "snn_ff_params.svh"

module synapse_array
    import aer_pkg::*;
    import neuron_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    // weight load port, one weight per cycle
    input  logic        prog_en,
    input  pre_addr_t   prog_pre,
    input  post_addr_t  prog_post,
    input  weight_t     prog_weight,
    // from input FIFO
    input  aer_in_t     ev_data,
    input  logic        ev_valid,
    output logic        ev_ready,
    // to neuron array
    output logic        syn_tick,
    output weight_row_t syn_row,
    output logic        syn_valid,
    input  logic        syn_ready
);

    weight_row_t weights [`SNN_NUM_PRE];    // row per input neuron
    logic        take;

    // ---------------------------------------------------------------------------
    // weight memory
    // ---------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (prog_en) begin
            weights[prog_pre][prog_post] <= prog_weight;    // single element write
        end
    end

    // ---------------------------------------------------------------------------
    // read stage, one register deep
    // ---------------------------------------------------------------------------
    assign ev_ready = !syn_valid || syn_ready;  // empty or draining this cycle
    assign take     = ev_valid && ev_ready;

    always_ff @(posedge CLK) begin
        if (rst) begin
            syn_valid <= 1'b0;
        end else if (take) begin
            syn_valid <= 1'b1;
        end else if (syn_ready) begin
            syn_valid <= 1'b0;
        end
    end

    // payload, held while downstream stalls
    always_ff @(posedge CLK) begin
        if (take) begin
            syn_tick <= ev_data.tick;
            if (!ev_data.tick) begin
                syn_row <= weights[ev_data.addr];   // tick leaves row untouched
            end
        end
    end

endmodule

/* snn_ff_core.f */
+incdir+logic
+incdir+verification
logic/aer_pkg.sv
logic/neuron_pkg.sv
logic/aer_receiver.sv
logic/event_fifo.sv
logic/synapse_array.sv
logic/neuron_array.sv
logic/aer_transmitter.sv
logic/snn_ff_core.sv
verification/snn_ff_core_tb.sv

/* verification/snn_ff_stim.svh */
`ifndef SNN_FF_STIM_SVH
`define SNN_FF_STIM_SVH

// ---------------------------------------------------------------------------
// random numbers
// ---------------------------------------------------------------------------
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;    // full-period 32-bit LCG
endfunction

// uniform draw in lo..hi from the upper half of the state
function automatic int rand_range(input int lo, input int hi);
    stim_seed = lcg_next(stim_seed);
    return lo + int'(stim_seed[31:16]) % (hi - lo + 1);
endfunction

// ---------------------------------------------------------------------------
// weight load, lower and upper output neurons drawn from separate ranges
// ---------------------------------------------------------------------------
task automatic program_weights(input int lo_a, input int hi_a, input int lo_b, input int hi_b);
    int w;
    for (int p = 0; p < `SNN_NUM_PRE; p++) begin
        for (int q = 0; q < `SNN_NUM_POST; q++) begin
            if (q < `SNN_NUM_POST / 2) begin
                w = rand_range(lo_a, hi_a);
            end else begin
                w = rand_range(lo_b, hi_b);
            end
            w_m[p][q]   = w;                    // model copy
            prog_en     <= 1'b1;
            prog_pre    <= pre_addr_t'(p);
            prog_post   <= post_addr_t'(q);
            prog_weight <= weight_t'(w);
            @(posedge CLK);
        end
    end
    prog_en <= 1'b0;
endtask

// ---------------------------------------------------------------------------
// one four-phase exchange on the input link
// ---------------------------------------------------------------------------
task automatic send_event(input aer_in_t ev);
    int waited;
    waited = 0;
    aer_in_addr <= ev;
    aer_in_req  <= 1'b1;
    @(posedge CLK);
    while (!aer_in_ack) begin
        @(posedge CLK);
        waited++;
    end
    if (waited > 2) begin
        held_off = 1'b1;    // input queue was full for a while
    end
    apply_model(ev);        // queued in the DUT, model follows
    aer_in_req <= 1'b0;
    @(posedge CLK);
    while (aer_in_ack) begin
        @(posedge CLK);
    end
endtask

// per_step random input events, then a tick, for every time step
task automatic run_sample(input int per_step);
    aer_in_t ev;
    for (int t = 0; t < `SNN_TIME_STEPS; t++) begin
        for (int e = 0; e < per_step; e++) begin
            ev.tick = 1'b0;
            ev.addr = pre_addr_t'(rand_range(0, `SNN_NUM_PRE - 1));
            send_event(ev);
        end
        ev.tick = 1'b1;
        ev.addr = '0;
        send_event(ev);
    end
endtask

// wait for the result and every expected spike, then a quiet gap
task automatic drain_output();
    while (done_cnt != sent_cnt || exp_q.size() != 0 || aer_out_req || aer_out_ack) begin
        @(posedge CLK);
    end
    repeat (20) @(posedge CLK);     // stray spikes would show up here
endtask

`endif

/* verification/snn_ff_core_tb.sv */
`timescale 1ns/10ps
`include "snn_ff_params.svh"

module snn_ff_core_tb
    import aer_pkg::*;
    import neuron_pkg::*;
();

    localparam logic [31:0] SEED     = 32'h9073_42f1;
    localparam int          MEM_TOP  = (1 << (`SNN_MEM_W - 1)) - 1;
    localparam int          CNT_MAX  = (1 << $clog2(`SNN_TIME_STEPS + 1)) - 1;
    localparam int          HALF     = `SNN_NUM_POST / 2;
    // three samples with 3, 2 and 8 events per time step
    localparam int          N_EVENTS = `SNN_TIME_STEPS * (3 + 2 + 8);
    localparam int          N_TICKS  = 3 * `SNN_TIME_STEPS;
    localparam int          N_PROG   = 3 * `SNN_NUM_PRE * `SNN_NUM_POST;
    localparam int          LIMIT    = N_EVENTS * 20 + N_TICKS * 40 + N_PROG + 8;

    logic       CLK;
    logic       rst;
    aer_in_t    aer_in_addr;
    logic       aer_in_req;
    logic       aer_in_ack;
    logic       prog_en;
    pre_addr_t  prog_pre;
    post_addr_t prog_post;
    weight_t    prog_weight;
    aer_out_t   aer_out_addr;
    logic       aer_out_req;
    logic       aer_out_ack = 1'b0;
    logic       sample_done;
    goodness_t  goodness;

    // reference model state
    int         w_m   [`SNN_NUM_PRE][`SNN_NUM_POST];
    int         mem_m [`SNN_NUM_POST];
    int         cnt_m [`SNN_NUM_POST];
    int         ticks_m;
    int         exp_good;
    aer_out_t   exp_q [$];              // fired indices not yet seen on the link
    int         sent_cnt;               // samples the model has closed
    int         done_cnt;               // sample_done pulses seen

    // output responder and checker state
    logic       chk_stb    = 1'b0;
    logic       want_ok    = 1'b0;
    aer_out_t   got_addr   = '0;
    aer_out_t   want_addr  = '0;
    int         ack_wait   = 0;
    logic [31:0] ack_seed  = SEED;
    logic [31:0] stim_seed = SEED;
    logic       slow_ack   = 1'b0;
    logic       clamp_mode = 1'b0;
    logic       held_off   = 1'b0;
    logic       rst_q      = 1'b0;
    int         cycles     = 0;
    int         errors     = 0;
    int         test_err0  = 0;
    int         n_tests    = 0;
    string      cur_test   = "reset";

    `include "snn_ff_stim.svh"

    snn_ff_core DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // clamp, threshold and reset rules, applied as each event is accepted
    task automatic apply_model(input aer_in_t ev);
        int s;
        int good;
        if (!ev.tick) begin
            for (int j = 0; j < `SNN_NUM_POST; j++) begin
                s = mem_m[j] + w_m[ev.addr][j];
                mem_m[j] = (s < 0) ? 0 : (s > MEM_TOP) ? MEM_TOP : s;
            end
        end else begin
            for (int j = 0; j < `SNN_NUM_POST; j++) begin
                if (mem_m[j] >= `SNN_THRESHOLD) begin
                    exp_q.push_back(aer_out_t'(j));     // ascending scan order
                    mem_m[j] = 0;
                    cnt_m[j] = (cnt_m[j] < CNT_MAX) ? cnt_m[j] + 1 : cnt_m[j];
                end
            end
            ticks_m++;
            if (ticks_m == `SNN_TIME_STEPS) begin
                good = 0;
                for (int j = 0; j < `SNN_NUM_POST; j++) begin
                    good += cnt_m[j] * cnt_m[j];
                    cnt_m[j] = 0;
                    mem_m[j] = 0;
                end
                exp_good = good;
                ticks_m  = 0;
                sent_cnt++;
            end
        end
    endtask

    task automatic note_fail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name);
        $display("test %s finished at %0t, %0d failed checks", name, $time, errors - test_err0);
        n_tests++;
        test_err0 = errors;
    endtask

    // ---------------------------------------------------------------------------
    // output link responder, random ack delay per req
    // ---------------------------------------------------------------------------
    always @(posedge CLK) begin
        chk_stb <= 1'b0;
        if (rst) begin
            aer_out_ack <= 1'b0;
            ack_wait    <= 0;
        end else if (aer_out_req && !aer_out_ack) begin
            if (ack_wait == 0) begin
                aer_out_ack <= 1'b1;
                got_addr    <= aer_out_addr;
                chk_stb     <= 1'b1;            // compare next cycle
                want_ok     <= (exp_q.size() != 0);
                if (exp_q.size() != 0) begin
                    want_addr <= exp_q.pop_front();
                end
                ack_seed = lcg_next(ack_seed);
                ack_wait <= int'(ack_seed[17:16]) + (slow_ack ? 3 : 0);
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end else if (!aer_out_req && aer_out_ack) begin
            aer_out_ack <= 1'b0;                // req gone, finish the exchange
        end
    end

    always @(posedge CLK) begin
        rst_q <= rst;
        if (sample_done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    // watchdog
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: test %s hung, run passed %0d cycles", cur_test, LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ---------------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------------
    reset_quiet: assert property (@(posedge CLK)
        rst_q |-> !aer_in_ack && !aer_out_req && !sample_done && goodness == '0)
        else note_fail("outputs not idle around reset");

    in_ack_rise: assert property (@(posedge CLK) disable iff (rst)
        $rose(aer_in_ack) |-> $past(aer_in_req))
        else note_fail("input ack rose without req");
    in_ack_hold: assert property (@(posedge CLK) disable iff (rst)
        aer_in_ack && aer_in_req |=> aer_in_ack)
        else note_fail("input ack dropped while req high");
    in_ack_fall: assert property (@(posedge CLK) disable iff (rst)
        aer_in_ack && !aer_in_req |=> !aer_in_ack)
        else note_fail("input ack stuck after req fell");

    out_req_rise: assert property (@(posedge CLK) disable iff (rst)
        $rose(aer_out_req) |-> !aer_out_ack)
        else note_fail("output req rose while ack high");
    out_req_hold: assert property (@(posedge CLK) disable iff (rst)
        aer_out_req && !aer_out_ack |=> aer_out_req)
        else note_fail("output req dropped before ack");
    out_req_drop: assert property (@(posedge CLK) disable iff (rst)
        aer_out_req && aer_out_ack |=> !aer_out_req)
        else note_fail("output req held after ack");
    out_addr_hold: assert property (@(posedge CLK) disable iff (rst)
        aer_out_req && $past(aer_out_req) |-> $stable(aer_out_addr))
        else note_fail("output address changed during req");

    spike_match: assert property (@(posedge CLK) disable iff (rst)
        chk_stb |-> want_ok && got_addr == want_addr)
        else note_fail($sformatf("spike %0d, expected %0d (queued %0b)",
                                 got_addr, want_addr, want_ok));

    done_pulse: assert property (@(posedge CLK) disable iff (rst)
        sample_done |=> !sample_done)
        else note_fail("sample_done longer than one cycle");
    done_count: assert property (@(posedge CLK) disable iff (rst)
        sample_done |-> done_cnt < sent_cnt)
        else note_fail("sample_done before the last tick of a sample");
    good_match: assert property (@(posedge CLK) disable iff (rst)
        sample_done |-> goodness == goodness_t'(exp_good))
        else note_fail($sformatf("goodness %0d, expected %0d", goodness, exp_good));

    // negative rows clamp at 0, strong rows fire every tick
    clamp_silent: assert property (@(posedge CLK) disable iff (rst)
        clamp_mode && chk_stb |-> got_addr >= HALF)
        else note_fail($sformatf("neuron %0d fired with negative weights", got_addr));
    clamp_good: assert property (@(posedge CLK) disable iff (rst)
        clamp_mode && sample_done |-> goodness == HALF * `SNN_TIME_STEPS * `SNN_TIME_STEPS)
        else note_fail($sformatf("clamp sample goodness %0d", goodness));

    // ---------------------------------------------------------------------------
    // test sequence
    // ---------------------------------------------------------------------------
    initial begin
        rst         = 1'b1;
        aer_in_addr = '0;
        aer_in_req  = 1'b0;
        prog_en     = 1'b0;
        prog_pre    = '0;
        prog_post   = '0;
        prog_weight = '0;
        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        repeat (4) @(posedge CLK);
        report_test("reset");

        cur_test = "random";
        program_weights(-40, 60, -40, 60);
        run_sample(3);
        drain_output();
        report_test("random");

        cur_test = "clamp";
        clamp_mode <= 1'b1;
        program_weights(-40, -1, 40, 60);   // two inputs always cross threshold
        run_sample(2);
        drain_output();
        clamp_mode <= 1'b0;
        report_test("clamp");

        cur_test = "back_pressure";
        slow_ack <= 1'b1;
        held_off = 1'b0;
        program_weights(0, 60, 0, 60);      // nearly every neuron fires each tick
        run_sample(8);
        drain_output();
        slow_ack <= 1'b0;
        assert (held_off) else note_fail("input ack was never held off by a full queue");
        report_test("back_pressure");

        $display("%0d tests run, %0d checks failed", n_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
